// File: files.f
source/cheri_alu_pkg.sv
source/cap_decode.sv
source/cap_violation_check.sv
source/cap_query_unit.sv
source/cap_modify_unit.sv
source/cap_result_stage.sv
source/cheri_alu_top.sv
tb/cheri_alu_assertions.sv
tb/cheri_alu_tb.sv

// File: source/cap_decode.sv
`timescale 1ns/1ps

module cap_decode import cheri_alu_pkg::*; (
  input  cap_t      cap_i,
  output cap_info_t info_o
);

  logic [KindStateWidth-1:0] kind_state;

  // field view of the kind word
  assign kind_state = cap_i.kind.fields.state;

  always_comb begin
    info_o = '0;

    info_o.valid    = cap_i.tag;
    // raw view is passed on for the type compare
    info_o.kind.raw = cap_i.kind.raw;
    info_o.sealed   = kind_state != KindUnsealed;
    info_o.otype    = cap_i.kind.fields.otype;

    info_o.perms = cap_i.perms;
    info_o.flag  = cap_i.flag;
    info_o.base  = cap_i.base;
    info_o.top   = cap_i.top;
    info_o.addr  = cap_i.addr;

    // bounds are stored exactly, so offset and length are plain differences
    info_o.offset     = cap_i.addr - cap_i.base;
    info_o.length     = cap_i.top - {1'b0, cap_i.base};
    info_o.below_base = cap_i.addr < cap_i.base;
  end

endmodule

// File: source/cap_modify_unit.sv
`timescale 1ns/1ps

module cap_modify_unit import cheri_alu_pkg::*; #(
  parameter logic [OTypeWidth-1:0] MaxOType = CheriMaxOType
) (
  input  cheri_op_e  op_i,
  input  cap_t       operand_a_i,
  input  cap_t       operand_b_i,
  input  cap_info_t  info_a_i,
  input  cap_info_t  info_b_i,
  input  cheri_exc_t common_a_i,
  input  cheri_exc_t common_b_i,
  output cap_t       cap_o,
  output cheri_exc_t exc_a_o,
  output cheri_exc_t exc_b_o
);

  localparam logic [OTypeWidth-1:0] SentryOType   = 4'hE;
  localparam logic [OTypeWidth-1:0] UnsealedOType = 4'hF;

  logic [TopWidth-1:0] new_top;
  logic                b_addr_past_top;
  logic                b_otype_too_big;

  //////////////////////////////
  // bounds and seal checks
  //////////////////////////////

  // top of the requested region, one bit wider so it cannot wrap
  assign new_top = {1'b0, info_a_i.addr} + {1'b0, operand_b_i.addr};

  assign b_addr_past_top = {1'b0, info_b_i.addr} >= info_b_i.top;
  assign b_otype_too_big = info_b_i.addr > IntWidth'(MaxOType);

  //////////////////////////////
  // result capability
  //////////////////////////////

  always_comb begin
    cap_o   = operand_a_i;
    exc_a_o = '0;
    exc_b_o = '0;

    case (op_i)
      OP_MOVE: begin
        cap_o = operand_a_i;
      end

      OP_CLEAR_TAG: begin
        cap_o.tag = 1'b0;
      end

      OP_AND_PERM: begin
        cap_o.perms  = info_a_i.perms & operand_b_i.addr[PermsWidth-1:0];
        exc_a_o.tag  = common_a_i.tag;
        exc_a_o.seal = common_a_i.seal;
      end

      OP_SET_FLAGS: begin
        cap_o.flag   = operand_b_i.addr[0];
        exc_a_o.seal = common_a_i.seal;
      end

      OP_SET_ADDR: begin
        cap_o.addr   = operand_b_i.addr;
        exc_a_o.seal = common_a_i.seal;
      end

      OP_SET_OFFSET: begin
        cap_o.addr   = info_a_i.base + operand_b_i.addr;
        exc_a_o.seal = common_a_i.seal;
      end

      OP_INC_OFFSET: begin
        cap_o.addr   = info_a_i.addr + operand_b_i.addr;
        exc_a_o.seal = common_a_i.seal;
      end

      OP_SET_BOUNDS: begin
        cap_o.base     = info_a_i.addr;
        cap_o.top      = new_top;
        exc_a_o.tag    = common_a_i.tag;
        exc_a_o.seal   = common_a_i.seal;
        exc_a_o.length = common_a_i.length | (new_top > info_a_i.top);
      end

      OP_SEAL: begin
        cap_o.kind.fields.state = KindSealedType;
        cap_o.kind.fields.otype = operand_b_i.addr[OTypeWidth-1:0];
        exc_a_o.tag       = common_a_i.tag;
        exc_a_o.seal      = common_a_i.seal;
        exc_b_o.tag       = common_b_i.tag;
        exc_b_o.seal      = common_b_i.seal;
        exc_b_o.perm_seal = common_b_i.perm_seal;
        exc_b_o.length    = common_b_i.length | b_addr_past_top | b_otype_too_big;
      end

      OP_SEAL_ENTRY: begin
        cap_o.kind.fields.state = KindSentry;
        cap_o.kind.fields.otype = SentryOType;
        exc_a_o.tag          = common_a_i.tag;
        exc_a_o.seal         = common_a_i.seal;
        exc_a_o.perm_execute = common_a_i.perm_execute;
      end

      OP_UNSEAL: begin
        cap_o.kind.fields.state = KindUnsealed;
        cap_o.kind.fields.otype = UnsealedOType;
        // global survives only if both caps carry it
        cap_o.perms[PermitGlobalIndex] = info_a_i.perms[PermitGlobalIndex] &
                                         info_b_i.perms[PermitGlobalIndex];
        exc_a_o.tag = common_a_i.tag;
        exc_a_o.seal = ~info_a_i.sealed;
        exc_b_o.tag = common_b_i.tag;
        exc_b_o.seal = info_b_i.sealed;
        exc_b_o.wrong_type = info_b_i.addr != IntWidth'(info_a_i.otype);
        exc_b_o.perm_unseal = common_b_i.perm_unseal;
        exc_b_o.length = b_addr_past_top;
      end

      default: begin
        // reads are handled by the query unit
        cap_o = operand_a_i;
      end
    endcase
  end

endmodule

// File: source/cap_query_unit.sv
`timescale 1ns/1ps

module cap_query_unit import cheri_alu_pkg::*; (
  input  cheri_op_e           op_i,
  input  cap_info_t           info_a_i,
  output logic [IntWidth-1:0] query_int_o,
  output logic                query_hit_o
);

  logic [IntWidth-1:0] type_value;
  logic [IntWidth-1:0] len_value;

  // unsealed caps report -1 as their type
  assign type_value = info_a_i.sealed ?
      {{(IntWidth-OTypeWidth){info_a_i.otype[OTypeWidth-1]}}, info_a_i.otype} :
      {IntWidth{1'b1}};

  // saturate a full 2^32 length
  assign len_value = info_a_i.length[TopWidth-1] ? {IntWidth{1'b1}} :
                     info_a_i.length[IntWidth-1:0];

  always_comb begin
    query_int_o = '0;
    query_hit_o = 1'b1;

    case (op_i)
      OP_GET_PERM:   query_int_o = IntWidth'(info_a_i.perms);
      OP_GET_TYPE:   query_int_o = type_value;
      OP_GET_BASE:   query_int_o = info_a_i.base;
      OP_GET_LEN:    query_int_o = len_value;
      OP_GET_TAG:    query_int_o = IntWidth'(info_a_i.valid);
      OP_GET_SEALED: query_int_o = IntWidth'(info_a_i.sealed);
      OP_GET_OFFSET: query_int_o = info_a_i.offset;
      OP_GET_ADDR:   query_int_o = info_a_i.addr;
      OP_GET_FLAGS:  query_int_o = IntWidth'(info_a_i.flag);
      default: begin
        // writes and unused encodings
        query_hit_o = 1'b0;
      end
    endcase
  end

endmodule

// File: source/cap_result_stage.sv
`timescale 1ns/1ps

module cap_result_stage import cheri_alu_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                valid_i,
  input  cheri_op_e           op_i,
  input  logic [IntWidth-1:0] query_int_i,
  input  logic                query_hit_i,
  input  cap_t                mod_cap_i,
  input  cheri_exc_t          mod_exc_a_i,
  input  cheri_exc_t          mod_exc_b_i,
  output logic                valid_o,
  output cap_t                result_o,
  output logic                wrote_cap_o,
  output cheri_exc_t          exc_a_o,
  output cheri_exc_t          exc_b_o
);

  logic       is_write;
  cap_t       result_d;
  logic       wrote_cap_d;
  cheri_exc_t exc_a_d;
  cheri_exc_t exc_b_d;

  // encodings past the last op produce an all zero result
  assign is_write = op_i inside {[OP_MOVE:OP_SEAL_ENTRY]};

  always_comb begin
    result_d    = '0;
    wrote_cap_d = 1'b0;
    exc_a_d     = '0;
    exc_b_d     = '0;

    if (query_hit_i) begin
      // integer lands in the low bits
      result_d.addr = query_int_i;
    end else if (is_write) begin
      result_d    = mod_cap_i;
      wrote_cap_d = 1'b1;
      exc_a_d     = mod_exc_a_i;
      exc_b_d     = mod_exc_b_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o     <= 1'b0;
      result_o    <= '0;
      wrote_cap_o <= 1'b0;
      exc_a_o     <= '0;
      exc_b_o     <= '0;
    end else begin
      valid_o <= valid_i;
      // outputs hold between operations
      if (valid_i) begin
        result_o    <= result_d;
        wrote_cap_o <= wrote_cap_d;
        exc_a_o     <= exc_a_d;
        exc_b_o     <= exc_b_d;
      end
    end
  end

endmodule

// File: source/cap_violation_check.sv
`timescale 1ns/1ps

module cap_violation_check import cheri_alu_pkg::*; (
  input  cap_info_t  info_a_i,
  input  cap_info_t  info_b_i,
  output cheri_exc_t common_a_o,
  output cheri_exc_t common_b_o
);

  // checks shared by both operands
  function automatic cheri_exc_t common_checks(cap_info_t info);
    cheri_exc_t exc;
    exc              = '0;
    exc.tag          = ~info.valid;
    exc.seal         = info.valid & info.sealed;
    exc.length       = info.below_base;
    exc.perm_execute = ~info.perms[PermitExecuteIndex];
    return exc;
  endfunction

  logic kind_match;

  // the two kinds compared as whole words
  assign kind_match = info_a_i.kind.raw == info_b_i.kind.raw;

  always_comb begin
    common_a_o            = common_checks(info_a_i);
    common_a_o.wrong_type = ~kind_match;
  end

  always_comb begin
    common_b_o = common_checks(info_b_i);

    // b is the authority for seal and unseal
    common_b_o.perm_seal   = ~info_b_i.perms[PermitSealIndex];
    common_b_o.perm_unseal = ~info_b_i.perms[PermitUnsealIndex];
  end

endmodule

// File: source/cheri_alu_pkg.sv
package cheri_alu_pkg;

  //////////////////////////////
  // widths and constants
  //////////////////////////////

  localparam int unsigned IntWidth       = 32;
  localparam int unsigned TopWidth       = IntWidth + 1;
  localparam int unsigned PermsWidth     = 12;
  localparam int unsigned OTypeWidth     = 4;
  localparam int unsigned KindStateWidth = 3;

  // largest object type that seal will accept
  localparam logic [OTypeWidth-1:0] CheriMaxOType = 4'hB;

  // permission bit positions
  localparam int unsigned PermitGlobalIndex  = 0;
  localparam int unsigned PermitExecuteIndex = 1;
  localparam int unsigned PermitSealIndex    = 7;
  localparam int unsigned PermitUnsealIndex  = 9;

  // sealing states held in the upper kind bits
  localparam logic [KindStateWidth-1:0] KindUnsealed   = 3'd0;
  localparam logic [KindStateWidth-1:0] KindSentry     = 3'd1;
  localparam logic [KindStateWidth-1:0] KindSealedType = 3'd4;

  //////////////////////////////
  // types
  //////////////////////////////

  typedef enum logic [4:0] {
    OP_GET_PERM,
    OP_GET_TYPE,
    OP_GET_BASE,
    OP_GET_LEN,
    OP_GET_TAG,
    OP_GET_SEALED,
    OP_GET_OFFSET,
    OP_GET_ADDR,
    OP_GET_FLAGS,
    OP_MOVE,
    OP_CLEAR_TAG,
    OP_AND_PERM,
    OP_SET_FLAGS,
    OP_SET_ADDR,
    OP_SET_OFFSET,
    OP_INC_OFFSET,
    OP_SET_BOUNDS,
    OP_SEAL,
    OP_UNSEAL,
    OP_SEAL_ENTRY
  } cheri_op_e;

  typedef struct packed {
    logic [KindStateWidth-1:0] state;
    logic [OTypeWidth-1:0]     otype;
  } kind_fields_t;

  // raw view for equality, field view for state and otype
  typedef union packed {
    logic [KindStateWidth+OTypeWidth-1:0] raw;
    kind_fields_t                         fields;
  } kind_u;

  typedef struct packed {
    logic                  tag;
    logic [PermsWidth-1:0] perms;
    kind_u                 kind;
    logic                  flag;
    logic [IntWidth-1:0]   base;
    logic [TopWidth-1:0]   top;
    logic [IntWidth-1:0]   addr;
  } cap_t;

  typedef struct packed {
    logic                  valid;
    logic                  sealed;
    kind_u                 kind;
    logic [OTypeWidth-1:0] otype;
    logic [PermsWidth-1:0] perms;
    logic                  flag;
    logic [IntWidth-1:0]   base;
    logic [TopWidth-1:0]   top;
    logic [IntWidth-1:0]   addr;
    logic [IntWidth-1:0]   offset;
    logic [TopWidth-1:0]   length;
    logic                  below_base;
  } cap_info_t;

  typedef struct packed {
    logic tag;
    logic seal;
    logic length;
    logic wrong_type;
    logic perm_seal;
    logic perm_unseal;
    logic perm_execute;
    logic reserved;
  } cheri_exc_t;

endpackage

// File: source/cheri_alu_top.sv
`timescale 1ns/1ps

module cheri_alu_top import cheri_alu_pkg::*; #(
  parameter logic [OTypeWidth-1:0] MaxOType = CheriMaxOType
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       valid_i,
  input  cheri_op_e  op_i,
  input  cap_t       operand_a_i,
  input  cap_t       operand_b_i,
  output logic       valid_o,
  output cap_t       result_o,
  output logic       wrote_cap_o,
  output cheri_exc_t exc_a_o,
  output cheri_exc_t exc_b_o
);

  cap_info_t           info_a;
  cap_info_t           info_b;
  cheri_exc_t          common_a;
  cheri_exc_t          common_b;
  logic [IntWidth-1:0] query_int;
  logic                query_hit;
  cap_t                mod_cap;
  cheri_exc_t          mod_exc_a;
  cheri_exc_t          mod_exc_b;

  //////////////////////////////
  // operand decode
  //////////////////////////////

  cap_decode u_cap_decode_a (
    .cap_i  (operand_a_i),
    .info_o (info_a)
  );

  cap_decode u_cap_decode_b (
    .cap_i  (operand_b_i),
    .info_o (info_b)
  );

  cap_violation_check u_cap_violation_check (
    .info_a_i   (info_a),
    .info_b_i   (info_b),
    .common_a_o (common_a),
    .common_b_o (common_b)
  );

  //////////////////////////////
  // read and write paths
  //////////////////////////////

  cap_query_unit u_cap_query_unit (
    .op_i        (op_i),
    .info_a_i    (info_a),
    .query_int_o (query_int),
    .query_hit_o (query_hit)
  );

  cap_modify_unit #(
    .MaxOType (MaxOType)
  ) u_cap_modify_unit (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .info_a_i    (info_a),
    .info_b_i    (info_b),
    .common_a_i  (common_a),
    .common_b_i  (common_b),
    .cap_o       (mod_cap),
    .exc_a_o     (mod_exc_a),
    .exc_b_o     (mod_exc_b)
  );

  // one register stage on the outputs
  cap_result_stage u_cap_result_stage (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .query_int_i (query_int),
    .query_hit_i (query_hit),
    .mod_cap_i   (mod_cap),
    .mod_exc_a_i (mod_exc_a),
    .mod_exc_b_i (mod_exc_b),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .wrote_cap_o (wrote_cap_o),
    .exc_a_o     (exc_a_o),
    .exc_b_o     (exc_b_o)
  );

endmodule

// File: tb/cheri_alu_assertions.sv
`timescale 1ns/1ps

module cheri_alu_assertions import cheri_alu_pkg::*; (
  input logic       clk_i,
  input logic       reset_i,
  input logic       valid_i,
  input cheri_op_e  op_i,
  input logic       valid_o,
  input logic       wrote_cap_o,
  input cheri_exc_t exc_a_o,
  input cheri_exc_t exc_b_o
);

  int unsigned error_count = 0;

  // no result leaves the stage right after reset
  reset_clears_valid: assert property (@(posedge clk_i) reset_i |=> !valid_o)
    else begin
      $error("valid_o high in the cycle after reset");
      error_count++;
    end

  // exactly one cycle of latency in both directions
  valid_follows_input: assert property (
    @(posedge clk_i) disable iff (reset_i) valid_i |=> valid_o)
    else begin
      $error("valid_o missing one cycle after valid_i");
      error_count++;
    end

  no_spurious_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) !valid_i |=> !valid_o)
    else begin
      $error("valid_o high without valid_i in the cycle before");
      error_count++;
    end

  // read results carry no capability write and no violations
  read_has_no_violation: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (valid_i && (op_i inside {[OP_GET_PERM:OP_GET_FLAGS]})) |=>
      (!wrote_cap_o && exc_a_o == '0 && exc_b_o == '0))
    else begin
      $error("read operation left wrote_cap_o or a violation vector set");
      error_count++;
    end

endmodule

bind cap_result_stage cheri_alu_assertions u_cheri_alu_assertions (.*);

// File: tb/cheri_alu_tb.sv
`timescale 1ns/1ps

module cheri_alu_tb import cheri_alu_pkg::*; ();

  localparam int unsigned TimeoutCycles = 20;

  logic        clk = 1'b0;
  logic        reset;
  logic        in_valid;
  cheri_op_e   op;
  cap_t        cap_a;
  cap_t        cap_b;
  logic        out_valid;
  cap_t        result;
  logic        wrote_cap;
  cheri_exc_t  exc_a;
  cheri_exc_t  exc_b;
  logic [31:0] lfsr_state = 32'h2cac;
  int unsigned check_count = 0;
  int unsigned error_count = 0;
  int unsigned assert_errors;

  cheri_alu_top u_cheri_alu_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .valid_i     (in_valid),
    .op_i        (op),
    .operand_a_i (cap_a),
    .operand_b_i (cap_b),
    .valid_o     (out_valid),
    .result_o    (result),
    .wrote_cap_o (wrote_cap),
    .exc_a_o     (exc_a),
    .exc_b_o     (exc_b)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // stimulus and reference
  //////////////////////////////

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int unsigned count);
    logic [31:0] value;
    value = '0;
    for (int unsigned i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return value;
  endfunction

  function automatic cap_t make_cap(input logic tag, input logic [KindStateWidth-1:0] state);
    cap_t cap;
    cap                   = '0;
    cap.tag               = tag;
    cap.perms             = PermsWidth'(take_bits(PermsWidth));
    cap.kind.fields.state = state;
    cap.kind.fields.otype = OTypeWidth'(take_bits(OTypeWidth));
    cap.flag              = take_bits(1) != 0;
    cap.base              = take_bits(16) << 12;
    cap.top               = {1'b0, cap.base} + TopWidth'(take_bits(16));
    cap.addr              = cap.base + take_bits(12);
    return cap;
  endfunction

  task automatic predict(input cheri_op_e o, input cap_t a, input cap_t b,
                         output cap_t res, output logic wrote,
                         output cheri_exc_t ea, output cheri_exc_t eb);
    logic                a_sealed;
    logic                b_sealed;
    logic [TopWidth-1:0] length;
    logic [TopWidth-1:0] new_top;
    logic [IntWidth-1:0] value;
    a_sealed = a.kind.fields.state != KindUnsealed;
    b_sealed = b.kind.fields.state != KindUnsealed;
    length   = a.top - {1'b0, a.base};
    new_top  = {1'b0, a.addr} + {1'b0, b.addr};
    res      = a;
    wrote    = 1'b1;
    ea       = '0;
    eb       = '0;
    value    = '0;
    case (o)
      OP_GET_PERM:   value = IntWidth'(a.perms);
      OP_GET_TYPE:   value = a_sealed ? {{28{a.kind.fields.otype[3]}}, a.kind.fields.otype} : '1;
      OP_GET_BASE:   value = a.base;
      OP_GET_LEN:    value = length[IntWidth] ? '1 : length[IntWidth-1:0];
      OP_GET_TAG:    value = IntWidth'(a.tag);
      OP_GET_SEALED: value = IntWidth'(a_sealed);
      OP_GET_OFFSET: value = a.addr - a.base;
      OP_GET_ADDR:   value = a.addr;
      OP_GET_FLAGS:  value = IntWidth'(a.flag);
      OP_CLEAR_TAG:  res.tag = 1'b0;
      OP_SET_FLAGS:  res.flag = b.addr[0];
      OP_SET_ADDR:   res.addr = b.addr;
      OP_SET_OFFSET: res.addr = a.base + b.addr;
      OP_INC_OFFSET: res.addr = a.addr + b.addr;
      OP_AND_PERM: begin
        res.perms = a.perms & b.addr[PermsWidth-1:0];
        ea.tag    = ~a.tag;
      end
      OP_SET_BOUNDS: begin
        res.base  = a.addr;
        res.top   = new_top;
        ea.tag    = ~a.tag;
        ea.seal   = a.tag & a_sealed;
        ea.length = (a.addr < a.base) || (new_top > a.top);
      end
      OP_SEAL: begin
        res.kind.fields.state = KindSealedType;
        res.kind.fields.otype = b.addr[OTypeWidth-1:0];
        ea.tag       = ~a.tag;
        ea.seal      = a.tag & a_sealed;
        eb.tag       = ~b.tag;
        eb.seal      = b.tag & b_sealed;
        eb.perm_seal = ~b.perms[PermitSealIndex];
        eb.length    = (b.addr < b.base) || ({1'b0, b.addr} >= b.top) ||
                       (b.addr > IntWidth'(CheriMaxOType));
      end
      OP_SEAL_ENTRY: begin
        res.kind.fields.state = KindSentry;
        res.kind.fields.otype = 4'hE;
        ea.tag          = ~a.tag;
        ea.seal         = a.tag & a_sealed;
        ea.perm_execute = ~a.perms[PermitExecuteIndex];
      end
      OP_UNSEAL: begin
        res.kind.fields.state = KindUnsealed;
        res.kind.fields.otype = 4'hF;
        res.perms[PermitGlobalIndex] = a.perms[PermitGlobalIndex] & b.perms[PermitGlobalIndex];
        ea.tag         = ~a.tag;
        ea.seal        = ~a_sealed;
        eb.tag         = ~b.tag;
        eb.seal        = b_sealed;
        eb.wrong_type  = b.addr != IntWidth'(a.kind.fields.otype);
        eb.perm_unseal = ~b.perms[PermitUnsealIndex];
        eb.length      = {1'b0, b.addr} >= b.top;
      end
      default: res = a;
    endcase
    if (o inside {[OP_AND_PERM:OP_INC_OFFSET]}) begin
      ea.seal = a.tag & a_sealed;
    end
    // integer result sits in the low bits and violations stay clear
    if (o inside {[OP_GET_PERM:OP_GET_FLAGS]}) begin
      res      = '0;
      res.addr = value;
      wrote    = 1'b0;
    end
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////

  task automatic compare(input string name, input logic [127:0] actual,
                         input logic [127:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic check_outputs(input string label, input cap_t exp_res, input logic exp_wrote,
                               input cheri_exc_t exp_a, input cheri_exc_t exp_b);
    compare({label, " result_o"}, 128'(result), 128'(exp_res));
    compare({label, " wrote_cap_o"}, 128'(wrote_cap), 128'(exp_wrote));
    compare({label, " exc_a_o"}, 128'(exc_a), 128'(exp_a));
    compare({label, " exc_b_o"}, 128'(exc_b), 128'(exp_b));
  endtask

  task automatic drive_op(input cheri_op_e o, input cap_t a, input cap_t b);
    in_valid = 1'b1;
    op       = o;
    cap_a    = a;
    cap_b    = b;
  endtask

  task automatic run_op(input cheri_op_e o, input cap_t a, input cap_t b);
    cap_t        exp_res;
    logic        exp_wrote;
    cheri_exc_t  exp_a;
    cheri_exc_t  exp_b;
    int unsigned cycles;
    predict(o, a, b, exp_res, exp_wrote, exp_a, exp_b);
    @(negedge clk);
    drive_op(o, a, b);
    @(negedge clk);
    in_valid = 1'b0;
    cycles   = 0;
    while (!out_valid && cycles < TimeoutCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!out_valid) begin
      $display("timeout: valid_o never rose for %s", o.name());
      $display("CHECKS FAILED");
      $finish;
    end else begin
      check_outputs(o.name(), exp_res, exp_wrote, exp_a, exp_b);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic check_idle(input string label);
    compare({label, " valid_o"}, 128'(out_valid), 128'(1'b0));
    check_outputs(label, '0, 1'b0, '0, '0);
  endtask

  task automatic end_test(input string name, input int unsigned errors_before);
    $display("test %s done with %0d errors", name, error_count - errors_before);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reads();
    int unsigned errors_before;
    cap_t        a;
    cap_t        b;
    errors_before = error_count;
    for (int n = 0; n < 3; n++) begin
      a = make_cap(1'b1, KindUnsealed);
      b = make_cap(1'b1, KindUnsealed);
      if (n == 2) begin
        // whole address space so the length saturates
        a.base = '0;
        a.top  = {1'b1, 32'h0};
      end
      for (int k = OP_GET_PERM; k <= OP_GET_FLAGS; k++) begin
        run_op(cheri_op_e'(k), a, b);
      end
    end
    a = make_cap(1'b1, KindSealedType);
    run_op(OP_GET_TYPE, a, b);
    run_op(OP_GET_SEALED, a, b);
    // an untagged cap still answers reads
    run_op(OP_GET_TAG, make_cap(1'b0, KindUnsealed), b);
    end_test("reads", errors_before);
  endtask

  task automatic test_simple_writes();
    int unsigned errors_before;
    cap_t        a;
    cap_t        b;
    errors_before = error_count;
    for (int n = 0; n < 3; n++) begin
      // valid unsealed, valid sealed, untagged sealed
      a = make_cap(n != 2, (n == 0) ? KindUnsealed : KindSealedType);
      b = make_cap(1'b1, KindUnsealed);
      for (int k = OP_MOVE; k <= OP_INC_OFFSET; k++) begin
        run_op(cheri_op_e'(k), a, b);
      end
    end
    end_test("writes", errors_before);
  endtask

  task automatic test_set_bounds();
    int unsigned errors_before;
    cap_t        a;
    cap_t        b;
    errors_before = error_count;
    a = make_cap(1'b1, KindUnsealed);
    b = make_cap(1'b1, KindUnsealed);
    a.base = 32'h1000;
    a.top  = 33'h2000;
    a.addr = 32'h1100;
    b.addr = 32'h0100;
    run_op(OP_SET_BOUNDS, a, b);
    // runs past the old top
    b.addr = 32'h1000;
    run_op(OP_SET_BOUNDS, a, b);
    a.addr = 32'h0800;
    b.addr = 32'h0010;
    run_op(OP_SET_BOUNDS, a, b);
    a.addr = 32'h1100;
    a.tag  = 1'b0;
    run_op(OP_SET_BOUNDS, a, b);
    a.tag = 1'b1;
    a.kind.fields.state = KindSealedType;
    run_op(OP_SET_BOUNDS, a, b);
    end_test("set_bounds", errors_before);
  endtask

  task automatic test_seal();
    int unsigned errors_before;
    cap_t        a;
    cap_t        b;
    errors_before = error_count;
    a = make_cap(1'b1, KindUnsealed);
    b = make_cap(1'b1, KindUnsealed);
    b.perms[PermitSealIndex] = 1'b1;
    b.base = 32'h0;
    b.top  = 33'h10;
    b.addr = 32'h5;
    run_op(OP_SEAL, a, b);
    // otype above the largest sealable type
    b.addr = 32'hC;
    run_op(OP_SEAL, a, b);
    b.top  = 33'h3;
    b.addr = 32'h3;
    run_op(OP_SEAL, a, b);
    b.top = 33'h10;
    b.tag = 1'b0;
    b.perms[PermitSealIndex] = 1'b0;
    run_op(OP_SEAL, a, b);
    b.tag = 1'b1;
    b.kind.fields.state = KindSealedType;
    run_op(OP_SEAL, a, b);
    a.perms[PermitExecuteIndex] = 1'b1;
    run_op(OP_SEAL_ENTRY, a, b);
    a.perms[PermitExecuteIndex] = 1'b0;
    run_op(OP_SEAL_ENTRY, a, b);
    a.kind.fields.state = KindSealedType;
    run_op(OP_SEAL_ENTRY, a, b);
    end_test("seal", errors_before);
  endtask

  task automatic test_unseal();
    int unsigned errors_before;
    cap_t        a;
    cap_t        b;
    errors_before = error_count;
    a = make_cap(1'b1, KindSealedType);
    a.kind.fields.otype = 4'h5;
    b = make_cap(1'b1, KindUnsealed);
    b.perms[PermitUnsealIndex] = 1'b1;
    b.base = 32'h0;
    b.top  = 33'h10;
    b.addr = 32'h5;
    run_op(OP_UNSEAL, a, b);
    b.addr = 32'h6;
    run_op(OP_UNSEAL, a, b);
    b.top  = 33'h5;
    b.addr = 32'h5;
    run_op(OP_UNSEAL, a, b);
    b.top = 33'h10;
    b.kind.fields.state = KindSealedType;
    b.perms[PermitUnsealIndex] = 1'b0;
    run_op(OP_UNSEAL, a, b);
    a.tag = 1'b0;
    a.kind.fields.state = KindUnsealed;
    run_op(OP_UNSEAL, a, b);
    end_test("unseal", errors_before);
  endtask

  task automatic test_pipeline();
    int unsigned errors_before;
    cheri_op_e   ops[4];
    cap_t        a_q[4];
    cap_t        b_q[4];
    cap_t        exp_res[4];
    logic        exp_wrote[4];
    cheri_exc_t  exp_a[4];
    cheri_exc_t  exp_b[4];
    errors_before = error_count;
    ops = '{OP_GET_ADDR, OP_SET_BOUNDS, OP_SEAL, OP_INC_OFFSET};
    for (int n = 0; n < 4; n++) begin
      a_q[n] = make_cap(1'b1, KindUnsealed);
      b_q[n] = make_cap(1'b1, KindUnsealed);
      predict(ops[n], a_q[n], b_q[n], exp_res[n], exp_wrote[n], exp_a[n], exp_b[n]);
    end
    @(negedge clk);
    // each result shows one cycle after its issue
    for (int n = 0; n <= 4; n++) begin
      if (n > 0) begin
        compare("pipeline valid_o", 128'(out_valid), 128'(1'b1));
        check_outputs("pipeline", exp_res[n-1], exp_wrote[n-1], exp_a[n-1], exp_b[n-1]);
      end
      if (n < 4) begin
        drive_op(ops[n], a_q[n], b_q[n]);
      end else begin
        in_valid = 1'b0;
      end
      @(negedge clk);
    end
    compare("pipeline valid_o", 128'(out_valid), 128'(1'b0));
    end_test("pipeline", errors_before);
  endtask

  task automatic test_reset();
    int unsigned errors_before;
    cap_t        b;
    errors_before = error_count;
    b = make_cap(1'b0, KindSealedType);
    run_op(OP_SEAL, make_cap(1'b1, KindUnsealed), b);
    apply_reset();
    check_idle("after reset");
    end_test("reset", errors_before);
  endtask

  initial begin
    in_valid = 1'b0;
    op       = OP_MOVE;
    cap_a    = '0;
    cap_b    = '0;
    apply_reset();
    check_idle("power on");
    test_reads();
    test_simple_writes();
    test_set_bounds();
    test_seal();
    test_unseal();
    test_pipeline();
    test_reset();
    assert_errors = u_cheri_alu_top.u_cap_result_stage.u_cheri_alu_assertions.error_count;
    $display("%0d checks, %0d errors, %0d assertion errors",
             check_count, error_count, assert_errors);
    if (error_count == 0 && assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
